// File: source/int_exec_pkg.sv
// Shared widths, vector types, opcode encodings and ALU operations for the
// RV64 integer execute path. Imported by the decoder, the stages and the testbench.
package int_exec_pkg;

  localparam int DWORD_WIDTH    = 64;
  localparam int WORD_WIDTH     = 32;
  localparam int INSTR_WIDTH    = 32;
  localparam int REG_ADDR_WIDTH = 5;
  localparam int REG_COUNT      = 32;
  localparam int VADDR_WIDTH    = 39;

  // Shift amount widths for 64-bit and word operations.
  localparam int SHAMT_WIDTH    = 6;
  localparam int SHAMTW_WIDTH   = 5;

  typedef logic [DWORD_WIDTH-1:0]    dword_t;
  typedef logic [INSTR_WIDTH-1:0]    instr_t;
  typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;
  typedef logic [VADDR_WIDTH-1:0]    vaddr_t;

  // Major opcodes of the supported instruction groups.
  localparam logic [6:0] OPC_OP        = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
  localparam logic [6:0] OPC_OP_32     = 7'b0111011;
  localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;
  localparam logic [6:0] OPC_LUI       = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC     = 7'b0010111;

  // The funct3 field of the integer groups.
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // The alternate funct7 selects sub and sra.
  localparam logic [6:0] FUNCT7_BASE = 7'b0000000;
  localparam logic [6:0] FUNCT7_ALT  = 7'b0100000;

  typedef enum logic [3:0] {
    e_int_op_add       = 4'd0,
    e_int_op_sub       = 4'd1,
    e_int_op_xor       = 4'd2,
    e_int_op_or        = 4'd3,
    e_int_op_and       = 4'd4,
    e_int_op_sll       = 4'd5,
    e_int_op_srl       = 4'd6,
    e_int_op_sra       = 4'd7,
    e_int_op_slt       = 4'd8,
    e_int_op_sltu      = 4'd9,
    e_int_op_pass_src2 = 4'd10
  } int_fu_op_e;

endpackage

// File: source/int_decode.sv
// Combinational decoder for the integer groups. Turns one instruction word into
// ALU controls, register indices and a sign-extended immediate.
`timescale 1ns/1ns

module int_decode (
  input  int_exec_pkg::instr_t     instr_i,
  output logic                     int_v_o,
  output int_exec_pkg::int_fu_op_e fu_op_o,
  output logic                     opw_o,
  output logic                     src1_sel_o,
  output logic                     src2_sel_o,
  output int_exec_pkg::reg_addr_t  rs1_addr_o,
  output int_exec_pkg::reg_addr_t  rs2_addr_o,
  output int_exec_pkg::reg_addr_t  rd_o,
  output int_exec_pkg::dword_t     imm_o
);
  import int_exec_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic [5:0] funct6;
  dword_t     imm_i_type;
  dword_t     imm_u_type;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];
  // 64-bit immediate shifts borrow bit 25 for the sixth shift amount bit.
  assign funct6 = instr_i[31:26];

  assign rd_o       = instr_i[11:7];
  assign rs1_addr_o = instr_i[19:15];
  assign rs2_addr_o = instr_i[24:20];

  assign imm_i_type = DWORD_WIDTH'($signed(instr_i[31:20]));
  assign imm_u_type = DWORD_WIDTH'($signed({instr_i[31:12], 12'b0}));

  always_comb begin
    int_v_o    = 1'b1;
    fu_op_o    = e_int_op_add;
    opw_o      = 1'b0;
    src1_sel_o = 1'b0;
    src2_sel_o = 1'b0;
    imm_o      = imm_i_type;

    case (opcode)
      OPC_OP: begin
        case ({funct7, funct3})
          {FUNCT7_BASE, F3_ADD_SUB}: fu_op_o = e_int_op_add;
          {FUNCT7_ALT,  F3_ADD_SUB}: fu_op_o = e_int_op_sub;
          {FUNCT7_BASE, F3_SLL}:     fu_op_o = e_int_op_sll;
          {FUNCT7_BASE, F3_SLT}:     fu_op_o = e_int_op_slt;
          {FUNCT7_BASE, F3_SLTU}:    fu_op_o = e_int_op_sltu;
          {FUNCT7_BASE, F3_XOR}:     fu_op_o = e_int_op_xor;
          {FUNCT7_BASE, F3_SRL_SRA}: fu_op_o = e_int_op_srl;
          {FUNCT7_ALT,  F3_SRL_SRA}: fu_op_o = e_int_op_sra;
          {FUNCT7_BASE, F3_OR}:      fu_op_o = e_int_op_or;
          {FUNCT7_BASE, F3_AND}:     fu_op_o = e_int_op_and;
          default:                   int_v_o = 1'b0;
        endcase
      end
      OPC_OP_IMM: begin
        src2_sel_o = 1'b1;
        case (funct3)
          F3_ADD_SUB: fu_op_o = e_int_op_add;
          F3_SLT:     fu_op_o = e_int_op_slt;
          F3_SLTU:    fu_op_o = e_int_op_sltu;
          F3_XOR:     fu_op_o = e_int_op_xor;
          F3_OR:      fu_op_o = e_int_op_or;
          F3_AND:     fu_op_o = e_int_op_and;
          F3_SLL: begin
            fu_op_o = e_int_op_sll;
            int_v_o = (funct6 == 6'b000000);
          end
          default: begin
            // Only srli and srai remain here.
            fu_op_o = funct6[4] ? e_int_op_sra : e_int_op_srl;
            int_v_o = (funct6 == 6'b000000) || (funct6 == 6'b010000);
          end
        endcase
      end
      OPC_OP_32: begin
        opw_o = 1'b1;
        case ({funct7, funct3})
          {FUNCT7_BASE, F3_ADD_SUB}: fu_op_o = e_int_op_add;
          {FUNCT7_ALT,  F3_ADD_SUB}: fu_op_o = e_int_op_sub;
          {FUNCT7_BASE, F3_SLL}:     fu_op_o = e_int_op_sll;
          {FUNCT7_BASE, F3_SRL_SRA}: fu_op_o = e_int_op_srl;
          {FUNCT7_ALT,  F3_SRL_SRA}: fu_op_o = e_int_op_sra;
          default:                   int_v_o = 1'b0;
        endcase
      end
      OPC_OP_IMM_32: begin
        opw_o      = 1'b1;
        src2_sel_o = 1'b1;
        case ({funct7, funct3}) inside
          {FUNCT7_BASE, F3_SLL}:     fu_op_o = e_int_op_sll;
          {FUNCT7_BASE, F3_SRL_SRA}: fu_op_o = e_int_op_srl;
          {FUNCT7_ALT,  F3_SRL_SRA}: fu_op_o = e_int_op_sra;
          {7'b???????,  F3_ADD_SUB}: fu_op_o = e_int_op_add;
          default:                   int_v_o = 1'b0;
        endcase
      end
      OPC_LUI: begin
        fu_op_o    = e_int_op_pass_src2;
        src2_sel_o = 1'b1;
        imm_o      = imm_u_type;
      end
      OPC_AUIPC: begin
        src1_sel_o = 1'b1;
        src2_sel_o = 1'b1;
        imm_o      = imm_u_type;
      end
      default: int_v_o = 1'b0;
    endcase
  end

endmodule

// File: source/int_regfile.sv
// Integer register file, 32 entries of 64 bits with two asynchronous read ports
// and one write port. Entry x0 is hardwired to zero.
`timescale 1ns/1ns

module int_regfile (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  int_exec_pkg::reg_addr_t rs1_addr_i,
  input  int_exec_pkg::reg_addr_t rs2_addr_i,
  output int_exec_pkg::dword_t    rs1_data_o,
  output int_exec_pkg::dword_t    rs2_data_o,
  input  logic                    wr_v_i,
  input  int_exec_pkg::reg_addr_t wr_addr_i,
  input  int_exec_pkg::dword_t    wr_data_i
);
  import int_exec_pkg::*;

  dword_t regs_q [REG_COUNT];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < REG_COUNT; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wr_v_i && (wr_addr_i != '0)) begin
      regs_q[wr_addr_i] <= wr_data_i;
    end
  end

  // A write shows up on the reads one cycle later; the dispatch bypass
  // covers the cycle in between.
  assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs_q[rs1_addr_i];
  assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs_q[rs2_addr_i];

endmodule

// File: source/int_dispatch_stage.sv
// First pipeline stage. Decodes the incoming instruction, reads and bypasses
// its operands and registers the dispatch bundle for the integer pipe.
`timescale 1ns/1ns

module int_dispatch_stage (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     instr_v_i,
  input  logic                     flush_i,
  input  int_exec_pkg::instr_t     instr_i,
  input  int_exec_pkg::vaddr_t     pc_i,
  input  logic                     wb_v_i,
  input  int_exec_pkg::reg_addr_t  wb_rd_i,
  input  int_exec_pkg::dword_t     wb_data_i,
  output int_exec_pkg::reg_addr_t  rf_rs1_addr_o,
  output int_exec_pkg::reg_addr_t  rf_rs2_addr_o,
  input  int_exec_pkg::dword_t     rf_rs1_data_i,
  input  int_exec_pkg::dword_t     rf_rs2_data_i,
  output logic                     disp_v_o,
  output logic                     disp_poison_o,
  output logic                     disp_int_v_o,
  output logic                     disp_opw_o,
  output logic                     disp_src1_sel_o,
  output logic                     disp_src2_sel_o,
  output int_exec_pkg::int_fu_op_e disp_fu_op_o,
  output int_exec_pkg::vaddr_t     disp_pc_o,
  output int_exec_pkg::dword_t     disp_rs1_o,
  output int_exec_pkg::dword_t     disp_rs2_o,
  output int_exec_pkg::dword_t     disp_imm_o,
  output int_exec_pkg::reg_addr_t  disp_rd_o
);
  import int_exec_pkg::*;

  logic       dec_int_v;
  int_fu_op_e dec_fu_op;
  logic       dec_opw;
  logic       dec_src1_sel;
  logic       dec_src2_sel;
  reg_addr_t  dec_rs1_addr;
  reg_addr_t  dec_rs2_addr;
  reg_addr_t  dec_rd;
  dword_t     dec_imm;
  logic       bypass_rs1;
  logic       bypass_rs2;
  logic       disp_v_q;

  int_decode decode0 (
    .instr_i    (instr_i),
    .int_v_o    (dec_int_v),
    .fu_op_o    (dec_fu_op),
    .opw_o      (dec_opw),
    .src1_sel_o (dec_src1_sel),
    .src2_sel_o (dec_src2_sel),
    .rs1_addr_o (dec_rs1_addr),
    .rs2_addr_o (dec_rs2_addr),
    .rd_o       (dec_rd),
    .imm_o      (dec_imm)
  );

  assign rf_rs1_addr_o = dec_rs1_addr;
  assign rf_rs2_addr_o = dec_rs2_addr;

  // The instruction in the pipe writes back on the same edge that this one is
  // captured, so its result is forwarded instead of the stale register value.
  assign bypass_rs1 = wb_v_i && (wb_rd_i == dec_rs1_addr) && (dec_rs1_addr != '0);
  assign bypass_rs2 = wb_v_i && (wb_rd_i == dec_rs2_addr) && (dec_rs2_addr != '0);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      disp_v_q <= 1'b0;
    end else begin
      disp_v_q <= instr_v_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (instr_v_i) begin
      disp_int_v_o    <= dec_int_v;
      disp_fu_op_o    <= dec_fu_op;
      disp_opw_o      <= dec_opw;
      disp_src1_sel_o <= dec_src1_sel;
      disp_src2_sel_o <= dec_src2_sel;
      disp_pc_o       <= pc_i;
      disp_rs1_o      <= bypass_rs1 ? wb_data_i : rf_rs1_data_i;
      disp_rs2_o      <= bypass_rs2 ? wb_data_i : rf_rs2_data_i;
      disp_imm_o      <= dec_imm;
      disp_rd_o       <= dec_rd;
    end
  end

  assign disp_v_o = disp_v_q;

  // Flush kills the held bundle before the pipe consumes it at the next edge.
  // The instruction arriving on that edge is not affected.
  assign disp_poison_o = disp_v_q & flush_i;

endmodule

// File: source/pipe_int.sv
// Integer pipe. Executes the dispatched bundle on a 64-bit ALU, drives the
// writeback to the register file and bypass, and registers the result.
`timescale 1ns/1ns

module pipe_int (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     disp_v_i,
  input  logic                     disp_poison_i,
  input  logic                     disp_int_v_i,
  input  int_exec_pkg::int_fu_op_e disp_fu_op_i,
  input  logic                     disp_opw_i,
  input  logic                     disp_src1_sel_i,
  input  logic                     disp_src2_sel_i,
  input  int_exec_pkg::vaddr_t     disp_pc_i,
  input  int_exec_pkg::dword_t     disp_rs1_i,
  input  int_exec_pkg::dword_t     disp_rs2_i,
  input  int_exec_pkg::dword_t     disp_imm_i,
  input  int_exec_pkg::reg_addr_t  disp_rd_i,
  output logic                     wb_v_o,
  output int_exec_pkg::reg_addr_t  wb_rd_o,
  output int_exec_pkg::dword_t     wb_data_o,
  output logic                     result_v_o,
  output int_exec_pkg::reg_addr_t  result_rd_o,
  output int_exec_pkg::dword_t     result_o
);
  import int_exec_pkg::*;

  dword_t                 pc_sext;
  dword_t                 src1;
  dword_t                 src2;
  dword_t                 alu_src1;
  dword_t                 alu_src2;
  logic [SHAMT_WIDTH-1:0] shamt;
  dword_t                 alu_result;
  dword_t                 opw_result;
  dword_t                 exe_result;
  logic                   result_v_q;

  // AUIPC adds to the PC as a signed 64-bit value.
  assign pc_sext = DWORD_WIDTH'($signed(disp_pc_i));

  assign src1 = disp_src1_sel_i ? pc_sext : disp_rs1_i;
  assign src2 = disp_src2_sel_i ? disp_imm_i : disp_rs2_i;

  assign shamt = disp_opw_i ? SHAMT_WIDTH'(src2[SHAMTW_WIDTH-1:0])
                            : src2[SHAMT_WIDTH-1:0];

  // Word operations run in the upper half, so the 64-bit operators give the
  // right carries, shifts and signs for 32 bits.
  assign alu_src1 = disp_opw_i ? (src1 << WORD_WIDTH) : src1;
  assign alu_src2 = disp_opw_i ? (src2 << WORD_WIDTH) : src2;

  always_comb begin
    case (disp_fu_op_i)
      e_int_op_add:       alu_result = alu_src1 + alu_src2;
      e_int_op_sub:       alu_result = alu_src1 - alu_src2;
      e_int_op_xor:       alu_result = alu_src1 ^ alu_src2;
      e_int_op_or:        alu_result = alu_src1 | alu_src2;
      e_int_op_and:       alu_result = alu_src1 & alu_src2;
      e_int_op_sll:       alu_result = alu_src1 << shamt;
      e_int_op_srl:       alu_result = alu_src1 >> shamt;
      e_int_op_sra:       alu_result = $signed(alu_src1) >>> shamt;
      e_int_op_slt:       alu_result = DWORD_WIDTH'($signed(alu_src1) < $signed(alu_src2));
      e_int_op_sltu:      alu_result = DWORD_WIDTH'(alu_src1 < alu_src2);
      e_int_op_pass_src2: alu_result = alu_src2;
      default:            alu_result = '0;
    endcase
  end

  // Bring a word result back down with its sign spread over the top half.
  assign opw_result = $signed(alu_result) >>> WORD_WIDTH;
  assign exe_result = disp_opw_i ? opw_result : alu_result;

  assign wb_v_o    = disp_v_i & ~disp_poison_i & disp_int_v_i;
  assign wb_rd_o   = disp_rd_i;
  assign wb_data_o = exe_result;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      result_v_q <= 1'b0;
    end else begin
      result_v_q <= wb_v_o;
    end
  end

  always_ff @(posedge clk_i) begin
    if (wb_v_o) begin
      result_rd_o <= disp_rd_i;
      result_o    <= exe_result;
    end
  end

  assign result_v_o = result_v_q;

endmodule

// File: source/int_exec_top.sv
// Integer execute path top level. Dispatch stage, register file and integer
// pipe; an instruction's result appears two cycles after it is sampled.
`timescale 1ns/1ns

module int_exec_top (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    instr_v_i,
  input  logic                    flush_i,
  input  int_exec_pkg::instr_t    instr_i,
  input  int_exec_pkg::vaddr_t    pc_i,
  output logic                    result_v_o,
  output int_exec_pkg::reg_addr_t result_rd_o,
  output int_exec_pkg::dword_t    result_o
);
  import int_exec_pkg::*;

  reg_addr_t  rf_rs1_addr;
  reg_addr_t  rf_rs2_addr;
  dword_t     rf_rs1_data;
  dword_t     rf_rs2_data;
  logic       wb_v;
  reg_addr_t  wb_rd;
  dword_t     wb_data;

  logic       disp_v;
  logic       disp_poison;
  logic       disp_int_v;
  int_fu_op_e disp_fu_op;
  logic       disp_opw;
  logic       disp_src1_sel;
  logic       disp_src2_sel;
  vaddr_t     disp_pc;
  dword_t     disp_rs1;
  dword_t     disp_rs2;
  dword_t     disp_imm;
  reg_addr_t  disp_rd;

  int_dispatch_stage dispatch0 (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .instr_v_i       (instr_v_i),
    .flush_i         (flush_i),
    .instr_i         (instr_i),
    .pc_i            (pc_i),
    .wb_v_i          (wb_v),
    .wb_rd_i         (wb_rd),
    .wb_data_i       (wb_data),
    .rf_rs1_addr_o   (rf_rs1_addr),
    .rf_rs2_addr_o   (rf_rs2_addr),
    .rf_rs1_data_i   (rf_rs1_data),
    .rf_rs2_data_i   (rf_rs2_data),
    .disp_v_o        (disp_v),
    .disp_poison_o   (disp_poison),
    .disp_int_v_o    (disp_int_v),
    .disp_opw_o      (disp_opw),
    .disp_src1_sel_o (disp_src1_sel),
    .disp_src2_sel_o (disp_src2_sel),
    .disp_fu_op_o    (disp_fu_op),
    .disp_pc_o       (disp_pc),
    .disp_rs1_o      (disp_rs1),
    .disp_rs2_o      (disp_rs2),
    .disp_imm_o      (disp_imm),
    .disp_rd_o       (disp_rd)
  );

  int_regfile regfile0 (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .rs1_addr_i (rf_rs1_addr),
    .rs2_addr_i (rf_rs2_addr),
    .rs1_data_o (rf_rs1_data),
    .rs2_data_o (rf_rs2_data),
    .wr_v_i     (wb_v),
    .wr_addr_i  (wb_rd),
    .wr_data_i  (wb_data)
  );

  pipe_int pipe0 (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .disp_v_i        (disp_v),
    .disp_poison_i   (disp_poison),
    .disp_int_v_i    (disp_int_v),
    .disp_fu_op_i    (disp_fu_op),
    .disp_opw_i      (disp_opw),
    .disp_src1_sel_i (disp_src1_sel),
    .disp_src2_sel_i (disp_src2_sel),
    .disp_pc_i       (disp_pc),
    .disp_rs1_i      (disp_rs1),
    .disp_rs2_i      (disp_rs2),
    .disp_imm_i      (disp_imm),
    .disp_rd_i       (disp_rd),
    .wb_v_o          (wb_v),
    .wb_rd_o         (wb_rd),
    .wb_data_o       (wb_data),
    .result_v_o      (result_v_o),
    .result_rd_o     (result_rd_o),
    .result_o        (result_o)
  );

endmodule

// File: verification/int_exec_checker.sv
// Checker for the integer execute path. Samples the DUT inputs, runs an ISA-level
// register model and compares every result pulse with the expected rd and value.
`timescale 1ns/1ns

module int_exec_checker (
  input logic                    clk_i,
  input logic                    rst_n_i,
  input logic                    instr_v_i,
  input logic                    flush_i,
  input int_exec_pkg::instr_t    instr_i,
  input int_exec_pkg::vaddr_t    pc_i,
  input logic                    result_v_i,
  input int_exec_pkg::reg_addr_t result_rd_i,
  input int_exec_pkg::dword_t    result_i
);
  import int_exec_pkg::*;

  dword_t    regs [REG_COUNT];
  int        exp_cyc_q [$];
  reg_addr_t exp_rd_q [$];
  dword_t    exp_val_q [$];
  int        cycle;
  logic      pend_v;
  instr_t    pend_instr;
  vaddr_t    pend_pc;
  int        pend_cycle;
  int        err_count;
  int        check_count;
  string     test_name;

  initial begin
    err_count   = 0;
    check_count = 0;
    cycle       = 0;
    pend_v      = 1'b0;
  end

  function automatic int outstanding();
    return exp_cyc_q.size() + int'(pend_v);
  endfunction

  // Full 64-bit semantics of the funct3 operations.
  function automatic dword_t alu64(input logic [2:0] f3, input logic alt,
                                   input dword_t a, input dword_t b);
    dword_t r;
    case (f3)
      3'd0: r = alt ? a - b : a + b;
      3'd1: r = a << b[5:0];
      3'd2: r = {63'b0, $signed(a) < $signed(b)};
      3'd3: r = {63'b0, a < b};
      3'd4: r = a ^ b;
      3'd5: begin
        if (alt) r = $signed(a) >>> b[5:0];
        else r = a >> b[5:0];
      end
      3'd6: r = a | b;
      default: r = a & b;
    endcase
    return r;
  endfunction

  // Word semantics: 32-bit operation, result sign-extended to 64 bits.
  function automatic dword_t alu32(input logic [2:0] f3, input logic alt,
                                   input logic [31:0] a, input logic [31:0] b);
    logic [31:0] r;
    r = '0;
    if (f3 == 3'd0) r = alt ? a - b : a + b;
    else if (f3 == 3'd1) r = a << b[4:0];
    else if (f3 == 3'd5 && alt) r = $signed(a) >>> b[4:0];
    else if (f3 == 3'd5) r = a >> b[4:0];
    return {{32{r[31]}}, r};
  endfunction

  // Returns {valid, value} for one instruction against the current model state.
  function automatic logic [64:0] model_exec(input instr_t ins, input vaddr_t pc);
    logic [6:0] opc;
    logic [2:0] f3;
    logic [6:0] f7;
    dword_t     a;
    dword_t     b;
    dword_t     immi;
    dword_t     immu;
    logic       ok;
    opc  = ins[6:0];
    f3   = ins[14:12];
    f7   = ins[31:25];
    a    = regs[ins[19:15]];
    b    = regs[ins[24:20]];
    immi = {{52{ins[31]}}, ins[31:20]};
    immu = {{32{ins[31]}}, ins[31:12], 12'b0};
    case (opc)
      OPC_OP: begin
        ok = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
        return {ok, alu64(f3, f7[5], a, b)};
      end
      OPC_OP_IMM: begin
        ok = 1'b1;
        if (f3 == 3'd1) ok = (ins[31:26] == 6'h00);
        if (f3 == 3'd5) ok = (ins[31:26] == 6'h00) || (ins[31:26] == 6'h10);
        return {ok, alu64(f3, (f3 == 3'd5) && ins[30], a, immi)};
      end
      OPC_OP_32: begin
        ok = ((f3 == 3'd0 || f3 == 3'd5) && (f7 == 7'h00 || f7 == 7'h20)) ||
             (f3 == 3'd1 && f7 == 7'h00);
        return {ok, alu32(f3, f7[5], a[31:0], b[31:0])};
      end
      OPC_OP_IMM_32: begin
        ok = (f3 == 3'd0) || (f3 == 3'd1 && f7 == 7'h00) ||
             (f3 == 3'd5 && (f7 == 7'h00 || f7 == 7'h20));
        return {ok, alu32(f3, (f3 == 3'd5) && f7[5], a[31:0], immi[31:0])};
      end
      OPC_LUI: return {1'b1, immu};
      OPC_AUIPC: return {1'b1, {{(DWORD_WIDTH-VADDR_WIDTH){pc[VADDR_WIDTH-1]}}, pc} + immu};
      default: return {1'b0, 64'b0};
    endcase
  endfunction

  // An instruction retires one edge after it is sampled, unless flush kills it then.
  always @(posedge clk_i) begin
    logic [64:0] res;
    if (!rst_n_i) begin
      for (int i = 0; i < REG_COUNT; i++) regs[i] = '0;
      exp_cyc_q.delete();
      exp_rd_q.delete();
      exp_val_q.delete();
      pend_v = 1'b0;
      cycle  = 0;
    end else begin
      cycle++;
      if (pend_v && !flush_i) begin
        res = model_exec(pend_instr, pend_pc);
        if (res[64]) begin
          exp_cyc_q.push_back(pend_cycle);
          exp_rd_q.push_back(pend_instr[11:7]);
          exp_val_q.push_back(res[63:0]);
          if (pend_instr[11:7] != 5'd0) regs[pend_instr[11:7]] = res[63:0];
        end
      end
      pend_v     = instr_v_i;
      pend_instr = instr_i;
      pend_pc    = pc_i;
      pend_cycle = cycle;
    end
  end

  always @(negedge clk_i) begin
    if (exp_cyc_q.size() > 0 && exp_cyc_q[0] + 1 == cycle) begin
      if (result_v_i !== 1'b1) begin
        $display("%s: no result for rd x%0d two cycles after its instruction",
                 test_name, exp_rd_q[0]);
        err_count++;
      end else begin
        check_count++;
        if (result_rd_i !== exp_rd_q[0]) begin
          $display("ERR %s rd: expected %0d actual %0d", test_name, exp_rd_q[0], result_rd_i);
          err_count++;
        end
        if (result_i !== exp_val_q[0]) begin
          $display("ERR %s value: expected %h actual %h", test_name, exp_val_q[0], result_i);
          err_count++;
        end
      end
      void'(exp_cyc_q.pop_front());
      void'(exp_rd_q.pop_front());
      void'(exp_val_q.pop_front());
    end else if (result_v_i !== 1'b0) begin
      $display("%s: result_v_o was high with no result expected", test_name);
      err_count++;
    end
  end

endmodule

// File: verification/tb_int_exec.sv
// Testbench for the integer execute path. Drives random instruction streams into
// the DUT on falling edges; the checker instance compares all results.
`timescale 1ns/1ns

module tb_int_exec;
  import int_exec_pkg::*;

  logic      clk_i;
  logic      rst_n_i;
  logic      instr_v_i;
  logic      flush_i;
  instr_t    instr_i;
  vaddr_t    pc_i;
  logic      result_v_o;
  reg_addr_t result_rd_o;
  dword_t    result_o;

  logic [63:0] lcg_state;
  reg_addr_t   last_rd;
  string       cur_test;
  int          err_base;
  int          tb_errors;
  int          tests_passed;
  int          tests_failed;

  int_exec_top dut0 (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .instr_v_i   (instr_v_i),
    .flush_i     (flush_i),
    .instr_i     (instr_i),
    .pc_i        (pc_i),
    .result_v_o  (result_v_o),
    .result_rd_o (result_rd_o),
    .result_o    (result_o)
  );

  int_exec_checker chk0 (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .instr_v_i   (instr_v_i),
    .flush_i     (flush_i),
    .instr_i     (instr_i),
    .pc_i        (pc_i),
    .result_v_i  (result_v_o),
    .result_rd_i (result_rd_o),
    .result_i    (result_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // 64-bit LCG; the upper half has the better random bits.
  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 64'd6364136223846793005 + 64'd1442695040888963407;
    return lcg_state[63:32];
  endfunction

  function automatic vaddr_t rand_pc();
    logic [63:0] v;
    v = {next_rand(), next_rand()};
    return v[VADDR_WIDTH-1:0];
  endfunction

  function automatic instr_t enc_r(input logic [6:0] f7, input reg_addr_t rs2,
                                   input reg_addr_t rs1, input logic [2:0] f3,
                                   input reg_addr_t rd, input logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  function automatic instr_t enc_i(input logic [11:0] imm, input reg_addr_t rs1,
                                   input logic [2:0] f3, input reg_addr_t rd,
                                   input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic instr_t enc_u(input logic [19:0] imm, input reg_addr_t rd,
                                   input logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  // Group 0 OP, 1 OP-IMM, 2 OP-32, 3 OP-IMM-32, 4 LUI, 5 AUIPC.
  // A chain reads the previous destination and sometimes writes x0.
  function automatic instr_t rand_instr(input int group, input logic chain);
    logic [31:0] r;
    logic [31:0] r2;
    reg_addr_t   rs1;
    reg_addr_t   rs2;
    reg_addr_t   rd;
    logic [2:0]  f3;
    logic        alt;
    logic [11:0] imm;
    r   = next_rand();
    r2  = next_rand();
    rs1 = (chain || r[0]) ? last_rd : r[5:1];
    rs2 = (chain && r[6]) ? last_rd : r[11:7];
    rd  = (chain && r[14:12] == 3'd0) ? 5'd0 : r[20:16];
    f3  = r[23:21];
    if ((group == 2) || (group == 3)) begin
      f3 = (r[22:21] == 2'd0) ? 3'd0 : (r[22:21] == 2'd1) ? 3'd1 : 3'd5;
    end
    alt = r[24] && ((f3 == 3'd0) || (f3 == 3'd5));
    case (group)
      0: return enc_r(alt ? FUNCT7_ALT : FUNCT7_BASE, rs2, rs1, f3, rd, OPC_OP);
      1: begin
        if (f3 == 3'd1) imm = {6'b0, r2[5:0]};
        else if (f3 == 3'd5) imm = {1'b0, alt, 4'b0, r2[5:0]};
        else imm = r2[31:20];
        return enc_i(imm, rs1, f3, rd, OPC_OP_IMM);
      end
      2: return enc_r(alt ? FUNCT7_ALT : FUNCT7_BASE, rs2, rs1, f3, rd, OPC_OP_32);
      3: begin
        if (f3 == 3'd0) imm = r2[31:20];
        else imm = {1'b0, alt && (f3 == 3'd5), 5'b0, r2[4:0]};
        return enc_i(imm, rs1, f3, rd, OPC_OP_IMM_32);
      end
      4: return enc_u(r2[31:12], rd, OPC_LUI);
      default: return enc_u(r2[31:12], rd, OPC_AUIPC);
    endcase
  endfunction

  task automatic issue(input instr_t ins, input vaddr_t pc, input logic flush);
    instr_v_i = 1'b1;
    instr_i   = ins;
    pc_i      = pc;
    flush_i   = flush;
    last_rd   = ins[11:7];
    @(negedge clk_i);
    instr_v_i = 1'b0;
    flush_i   = 1'b0;
  endtask

  task automatic start_test(input string name);
    cur_test       = name;
    chk0.test_name = name;
    err_base       = chk0.err_count + tb_errors;
  endtask

  // Waits for every outstanding result, then reports the test.
  task automatic finish_test();
    int n;
    int errs;
    n = 0;
    @(posedge clk_i);
    while (chk0.outstanding() != 0 && n < 16) begin
      @(posedge clk_i);
      n++;
    end
    if (chk0.outstanding() != 0) begin
      $display("%s: timed out waiting for the DUT results", cur_test);
      tb_errors++;
    end
    @(negedge clk_i);
    @(posedge clk_i);
    errs = chk0.err_count + tb_errors - err_base;
    if (errs == 0) begin
      tests_passed++;
      $display("PASS %s", cur_test);
    end else begin
      tests_failed++;
      $display("FAIL %s with %0d errors", cur_test, errs);
    end
    @(negedge clk_i);
  endtask

  initial begin
    instr_t    ins;
    vaddr_t    pc;
    reg_addr_t rd2;
    rst_n_i      = 1'b0;
    instr_v_i    = 1'b0;
    flush_i      = 1'b0;
    instr_i      = '0;
    pc_i         = '0;
    lcg_state    = 64'd57;
    last_rd      = '0;
    tb_errors    = 0;
    tests_passed = 0;
    tests_failed = 0;

    start_test("reset_idle");
    repeat (8) @(negedge clk_i);
    rst_n_i = 1'b1;
    repeat (6) @(negedge clk_i);
    finish_test();

    // Fills every register so the random tests see nonzero operands.
    start_test("lui_auipc");
    for (int i = 1; i < REG_COUNT; i++) begin
      issue(enc_u(20'(next_rand()), reg_addr_t'(i), OPC_LUI), rand_pc(), 1'b0);
      issue(enc_i(12'(next_rand()), reg_addr_t'(i), F3_XOR, reg_addr_t'(i), OPC_OP_IMM),
            rand_pc(), 1'b0);
    end
    for (int i = 0; i < 40; i++) begin
      pc = rand_pc();
      pc[VADDR_WIDTH-1] = i[0];
      issue(rand_instr(5, 1'b0), pc, 1'b0);
    end
    finish_test();

    start_test("alu64");
    repeat (300) issue(rand_instr(int'(next_rand() % 2), 1'b0), rand_pc(), 1'b0);
    finish_test();

    start_test("word_ops");
    repeat (300) issue(rand_instr(2 + int'(next_rand() % 2), 1'b0), rand_pc(), 1'b0);
    finish_test();

    start_test("dependent_chains");
    repeat (300) issue(rand_instr(int'(next_rand() % 6), 1'b1), rand_pc(), 1'b0);
    finish_test();

    // Each killed or unsupported instruction is followed by a read of its rd.
    start_test("flush_unsupported");
    for (int i = 0; i < 40; i++) begin
      rd2 = reg_addr_t'(next_rand() % 31 + 1);
      if (i[0]) begin
        issue(rand_instr(int'(next_rand() % 4), 1'b0), rand_pc(), 1'b0);
        issue(enc_r(FUNCT7_BASE, 5'd0, last_rd, F3_OR, rd2, OPC_OP), rand_pc(), 1'b1);
      end else begin
        ins = enc_i(12'(next_rand()), rd2, F3_ADD_SUB, reg_addr_t'(next_rand()),
                    next_rand() % 2 ? 7'b0000011 : 7'b1100011);
        issue(ins, rand_pc(), 1'b0);
        issue(enc_r(FUNCT7_BASE, 5'd0, last_rd, F3_OR, rd2, OPC_OP), rand_pc(), 1'b0);
      end
      issue(enc_r(FUNCT7_BASE, rd2, rd2, F3_ADD_SUB, rd2, OPC_OP), rand_pc(), 1'b0);
    end
    finish_test();

    @(posedge clk_i);
    $display("Tests passed %0d, failed %0d, results checked %0d, errors %0d",
             tests_passed, tests_failed, chk0.check_count, chk0.err_count + tb_errors);
    if (tests_failed == 0 && chk0.err_count + tb_errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// File: flist.f
source/int_exec_pkg.sv
source/int_decode.sv
source/int_regfile.sv
source/int_dispatch_stage.sv
source/pipe_int.sv
source/int_exec_top.sv
verification/int_exec_checker.sv
verification/tb_int_exec.sv
